// File: tlb_unit.f
source/tlb_pkg.sv
source/tlbop_pkg.sv
source/tlb_cmd_decode.sv
source/tlb_array.sv
source/tlb_lookup.sv
source/tlb_unit.sv
bench/tb_tlb_unit.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f tlb_unit.f --top-module tb_tlb_unit -o sim_tlb_unit

./obj_dir/sim_tlb_unit | tee sim.log

grep -qx "Test OK" sim.log
echo "simulation passed"

// File: bench/tb_tlb_unit.sv
module tb_tlb_unit;

    localparam int TLBNUM = 16;
    localparam int IW = $clog2(TLBNUM);
    // reset, empty probes, fills, random write/read, lookups, same-cycle case, 8 invtlb rounds
    localparam int RUN_CYCLES = 5 + 4 + 6 + 2 * (TLBNUM - 3) + 2 * TLBNUM + 2
                              + 8 * (2 * TLBNUM + 1) + 3;
    localparam int WATCHDOG_TIME = (RUN_CYCLES + 100) * 8;

    localparam tlbop_pkg::tlb_cmd_t  NO_CMD = '0;
    localparam tlb_pkg::lookup_req_t NO_REQ = '0;

    logic                 clk;
    logic                 arst_n;
    tlbop_pkg::tlb_cmd_t  cmd;
    tlb_pkg::lookup_req_t fetch_req;
    tlb_pkg::fetch_tag_t  fetch_tag;
    tlb_pkg::lookup_req_t lsu_req;
    tlb_pkg::lsu_tag_t    lsu_tag;
    tlb_pkg::lookup_rsp_t fetch_rsp;
    logic [IW-1:0]        fetch_index;
    tlb_pkg::fetch_tag_t  fetch_rsp_tag;
    tlb_pkg::lookup_rsp_t lsu_rsp;
    logic [IW-1:0]        lsu_index;
    tlb_pkg::lsu_tag_t    lsu_rsp_tag;
    logic                 rd_valid;
    tlb_pkg::entry_t      rd_entry;
    logic                 op_error;

    // shadow of the table and the expected registered outputs
    tlb_pkg::entry_t      model [TLBNUM];
    logic [IW-1:0]        model_fill;
    tlb_pkg::lookup_rsp_t exp_fetch;
    tlb_pkg::lookup_rsp_t exp_lsu;
    logic [IW-1:0]        exp_fetch_index;
    logic [IW-1:0]        exp_lsu_index;
    tlb_pkg::fetch_tag_t  exp_fetch_tag;
    tlb_pkg::lsu_tag_t    exp_lsu_tag;
    logic                 exp_rd_valid;
    tlb_pkg::entry_t      exp_rd_entry;
    logic                 exp_op_error;

    int          lookup_errors = 0;
    int          read_errors = 0;
    int          flag_errors = 0;
    logic [31:0] lfsr = 32'h85393e6d;

    tlb_unit #(
        .TLBNUM (TLBNUM)
    ) uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .cmd           (cmd),
        .fetch_req     (fetch_req),
        .fetch_tag     (fetch_tag),
        .lsu_req       (lsu_req),
        .lsu_tag       (lsu_tag),
        .fetch_rsp     (fetch_rsp),
        .fetch_index   (fetch_index),
        .fetch_rsp_tag (fetch_rsp_tag),
        .lsu_rsp       (lsu_rsp),
        .lsu_index     (lsu_index),
        .lsu_rsp_tag   (lsu_rsp_tag),
        .rd_valid      (rd_valid),
        .rd_entry      (rd_entry),
        .op_error      (op_error)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // vppn bits 13:10 carry the slot so no two slots overlap
    function automatic tlb_pkg::entry_t make_entry(input int slot, input logic [5:0] ps,
                                                   input logic g, input logic [9:0] asid);
        tlb_pkg::entry_t en;
        en.e     = 1'b1;
        en.vppn  = {5'(rand_bits(5)), 4'(slot), 10'(rand_bits(10))};
        en.ps    = ps;
        en.asid  = asid;
        en.g     = g;
        en.page0 = 26'(rand_bits(26));
        en.page1 = 26'(rand_bits(26));
        return en;
    endfunction

    function automatic tlb_pkg::entry_t stored_form(input tlb_pkg::entry_t en);
        if (en.ps != tlb_pkg::PS_4M) begin
            en.ps = tlb_pkg::PS_4K;
        end
        return en;
    endfunction

    function automatic tlbop_pkg::tlb_cmd_t make_cmd(input tlbop_pkg::tlb_op_e op,
                                                     input int index,
                                                     input tlb_pkg::entry_t en);
        tlbop_pkg::tlb_cmd_t c;
        c       = '0;
        c.valid = 1'b1;
        c.op    = op;
        c.index = 4'(index);
        c.entry = en;
        return c;
    endfunction

    function automatic tlbop_pkg::tlb_cmd_t inv_cmd(input int sub_op, input logic [9:0] asid,
                                                    input logic [18:0] vppn);
        tlbop_pkg::tlb_cmd_t c;
        c        = '0;
        c.valid  = 1'b1;
        c.op     = tlbop_pkg::OP_INV;
        c.inv_op = tlbop_pkg::inv_op_e'(5'(sub_op));
        c.asid   = asid;
        c.vppn   = vppn;
        return c;
    endfunction

    function automatic tlb_pkg::lookup_req_t rand_req();
        tlb_pkg::lookup_req_t r;
        r.valid    = 1'b1;
        r.vppn     = 19'(rand_bits(19));
        r.va_bit12 = 1'(rand_bits(1));
        r.asid     = 10'(rand_bits(10));
        return r;
    endfunction

    // request aimed at an entry, odd picks the half of the pair
    function automatic tlb_pkg::lookup_req_t probe_req(input tlb_pkg::entry_t en,
                                                       input logic [9:0] asid, input logic odd);
        tlb_pkg::lookup_req_t r;
        r.valid    = 1'b1;
        r.vppn     = en.vppn;
        r.va_bit12 = odd;
        r.asid     = asid;
        if (en.ps == tlb_pkg::PS_4M) begin
            r.vppn[9:0] = 10'(rand_bits(10));
            r.vppn[8]   = odd;
            r.va_bit12  = 1'(rand_bits(1));
        end
        return r;
    endfunction

    function automatic void model_lookup(input tlb_pkg::lookup_req_t r,
                                         output tlb_pkg::lookup_rsp_t rsp,
                                         output logic [IW-1:0] idx);
        logic big;
        rsp       = '0;
        idx       = '0;
        rsp.valid = r.valid;
        for (int k = 0; k < TLBNUM; k++) begin
            big = (model[k].ps == tlb_pkg::PS_4M);
            if (r.valid && model[k].e && model[k].vppn[18:10] == r.vppn[18:10]
                    && (big || model[k].vppn[9:0] == r.vppn[9:0])
                    && (model[k].g || model[k].asid == r.asid)) begin
                rsp.found = 1'b1;
                rsp.ps    = model[k].ps;
                rsp.page  = (big ? r.vppn[8] : r.va_bit12) ? model[k].page1 : model[k].page0;
                idx       = IW'(k);
            end
        end
    endfunction

    function automatic logic inv_hits(input tlbop_pkg::tlb_cmd_t c, input tlb_pkg::entry_t en);
        logic same_asid;
        logic va;
        same_asid = (en.asid == c.asid);
        va = (en.vppn[18:10] == c.vppn[18:10])
             && (en.ps == tlb_pkg::PS_4M || en.vppn[9:0] == c.vppn[9:0]);
        case (int'(c.inv_op))
            0, 1:    return 1'b1;
            2:       return en.g;
            3:       return !en.g;
            4:       return !en.g && same_asid;
            5:       return !en.g && same_asid && va;
            6:       return (en.g || same_asid) && va;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic rsp_ok(input tlb_pkg::lookup_rsp_t got,
                                    input tlb_pkg::lookup_rsp_t exp);
        if (got.valid !== exp.valid || got.found !== exp.found) begin
            return 1'b0;
        end
        return !exp.valid || got === exp;
    endfunction

    always @(posedge clk or negedge arst_n) begin : model_update
        tlb_pkg::lookup_rsp_t f_rsp;
        tlb_pkg::lookup_rsp_t l_rsp;
        logic [IW-1:0]        f_idx;
        logic [IW-1:0]        l_idx;
        logic [IW-1:0]        slot;
        if (!arst_n) begin
            for (int k = 0; k < TLBNUM; k++) begin
                model[k] <= '0;
            end
            model_fill   <= '0;
            exp_fetch    <= '0;
            exp_lsu      <= '0;
            exp_rd_valid <= 1'b0;
            exp_op_error <= 1'b0;
        end else begin
            // lookups see the table as it was before this edge
            model_lookup(fetch_req, f_rsp, f_idx);
            model_lookup(lsu_req, l_rsp, l_idx);
            exp_fetch <= f_rsp;
            exp_lsu   <= l_rsp;
            if (fetch_req.valid) begin
                exp_fetch_index <= f_idx;
                exp_fetch_tag   <= fetch_tag;
            end
            if (lsu_req.valid) begin
                exp_lsu_index <= l_idx;
                exp_lsu_tag   <= lsu_tag;
            end
            exp_rd_valid <= cmd.valid && cmd.op == tlbop_pkg::OP_RD;
            exp_op_error <= cmd.valid && cmd.op == tlbop_pkg::OP_INV && int'(cmd.inv_op) > 6;
            if (cmd.valid) begin
                case (cmd.op)
                    tlbop_pkg::OP_WR, tlbop_pkg::OP_FILL: begin
                        slot = (cmd.op == tlbop_pkg::OP_FILL) ? model_fill : cmd.index[IW-1:0];
                        model[slot] <= stored_form(cmd.entry);
                        if (cmd.op == tlbop_pkg::OP_FILL) begin
                            model_fill <= IW'(model_fill + 1);
                        end
                    end
                    tlbop_pkg::OP_RD: exp_rd_entry <= model[cmd.index[IW-1:0]];
                    default: begin
                        for (int k = 0; k < TLBNUM; k++) begin
                            if (inv_hits(cmd, model[k])) begin
                                model[k].e <= 1'b0;
                            end
                        end
                    end
                endcase
            end
        end
    end

    a_fetch_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_ok(fetch_rsp, exp_fetch)
    ) else begin
        lookup_errors++;
        $display("Error fetch_rsp: got %h expected %h", $sampled(fetch_rsp), $sampled(exp_fetch));
    end

    a_fetch_id: assert property (@(posedge clk) disable iff (!arst_n)
        !exp_fetch.valid || (fetch_index === exp_fetch_index && fetch_rsp_tag === exp_fetch_tag)
    ) else begin
        lookup_errors++;
        $display("Error fetch_index/fetch_rsp_tag: got %h/%h expected %h/%h",
                 $sampled(fetch_index), $sampled(fetch_rsp_tag),
                 $sampled(exp_fetch_index), $sampled(exp_fetch_tag));
    end

    a_lsu_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_ok(lsu_rsp, exp_lsu)
    ) else begin
        lookup_errors++;
        $display("Error lsu_rsp: got %h expected %h", $sampled(lsu_rsp), $sampled(exp_lsu));
    end

    a_lsu_id: assert property (@(posedge clk) disable iff (!arst_n)
        !exp_lsu.valid || (lsu_index === exp_lsu_index && lsu_rsp_tag === exp_lsu_tag)
    ) else begin
        lookup_errors++;
        $display("Error lsu_index/lsu_rsp_tag: got %h/%h expected %h/%h",
                 $sampled(lsu_index), $sampled(lsu_rsp_tag),
                 $sampled(exp_lsu_index), $sampled(exp_lsu_tag));
    end

    a_rd_valid: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid === exp_rd_valid
    ) else begin
        read_errors++;
        $display("Error rd_valid: got %h expected %h", $sampled(rd_valid), $sampled(exp_rd_valid));
    end

    a_rd_entry: assert property (@(posedge clk) disable iff (!arst_n)
        !exp_rd_valid || rd_entry === exp_rd_entry
    ) else begin
        read_errors++;
        $display("Error rd_entry: got %h expected %h", $sampled(rd_entry), $sampled(exp_rd_entry));
    end

    a_op_error: assert property (@(posedge clk) disable iff (!arst_n)
        op_error === exp_op_error
    ) else begin
        flag_errors++;
        $display("Error op_error: got %h expected %h", $sampled(op_error), $sampled(exp_op_error));
    end

    task automatic drive(input tlbop_pkg::tlb_cmd_t c, input tlb_pkg::lookup_req_t f,
                         input tlb_pkg::lookup_req_t l);
        @(negedge clk);
        cmd       = c;
        fetch_req = f;
        lsu_req   = l;
        fetch_tag = 8'(rand_bits(8));
        lsu_tag   = 6'(rand_bits(6));
    endtask

    // every third entry 4MB, every fourth global, asid alternates in pairs
    task automatic load_mixed_table(input logic [9:0] asid_a, input logic [9:0] asid_b);
        tlb_pkg::entry_t en;
        for (int k = 0; k < TLBNUM; k++) begin
            en = make_entry(k, (k % 3 == 0) ? tlb_pkg::PS_4M : tlb_pkg::PS_4K, k % 4 == 0,
                            k[1] ? asid_a : asid_b);
            drive(make_cmd(tlbop_pkg::OP_WR, k, en), NO_REQ, NO_REQ);
        end
    endtask

    task automatic probe_all(input logic [9:0] asid);
        for (int k = 0; k < TLBNUM; k++) begin
            drive(NO_CMD, probe_req(model[k], model[k].asid, 1'(rand_bits(1))),
                  probe_req(model[k], asid, 1'(k)));
        end
    endtask

    initial begin : stimulus
        tlb_pkg::entry_t en;
        tlb_pkg::entry_t old;
        logic [5:0]      ps;
        logic [9:0]      asid_a;
        logic [9:0]      asid_b;
        cmd       = NO_CMD;
        fetch_req = NO_REQ;
        lsu_req   = NO_REQ;
        fetch_tag = '0;
        lsu_tag   = '0;
        arst_n    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // empty table right after reset
        repeat (4) drive(NO_CMD, rand_req(), rand_req());

        // fills land in slots 0, 1, 2 whatever index is given
        for (int k = 0; k < 3; k++) begin
            en = make_entry(k, (k == 1) ? tlb_pkg::PS_4M : tlb_pkg::PS_4K, k == 2,
                            10'(rand_bits(10)));
            drive(make_cmd(tlbop_pkg::OP_FILL, int'(rand_bits(4)), en), NO_REQ, NO_REQ);
        end
        for (int k = 0; k < 3; k++) begin
            drive(make_cmd(tlbop_pkg::OP_RD, k, '0),
                  probe_req(model[k], model[k].asid, 1'(rand_bits(1))), NO_REQ);
        end

        // random entries, ps sometimes neither 12 nor 21
        for (int k = 3; k < TLBNUM; k++) begin
            ps = (rand_bits(2) == 0) ? tlb_pkg::PS_4M : 6'(rand_bits(6));
            en = make_entry(k, ps, 1'(rand_bits(1)), 10'(rand_bits(10)));
            en.e = (rand_bits(3) != 0);
            drive(make_cmd(tlbop_pkg::OP_WR, k, en), NO_REQ, NO_REQ);
            drive(make_cmd(tlbop_pkg::OP_RD, k, '0), NO_REQ, NO_REQ);
        end

        // both halves of each pair, foreign asid on the lsu port
        for (int k = 0; k < 2 * TLBNUM; k++) begin
            drive(NO_CMD, probe_req(model[k / 2], model[k / 2].asid, 1'(k)),
                  probe_req(model[k / 2], model[k / 2].asid ^ 10'h1, 1'(k)));
        end

        // write and lookup in one cycle
        old = model[5];
        en  = make_entry(5, tlb_pkg::PS_4K, 1'b0, 10'(rand_bits(10)));
        drive(make_cmd(tlbop_pkg::OP_WR, 5, en), probe_req(old, old.asid, 1'b0),
              probe_req(en, en.asid, 1'b1));
        drive(NO_CMD, probe_req(old, old.asid, 1'b0), probe_req(en, en.asid, 1'b1));

        asid_a = 10'(rand_bits(10));
        asid_b = asid_a ^ 10'h155;
        for (int op = 0; op < 7; op++) begin
            load_mixed_table(asid_a, asid_b);
            drive(inv_cmd(op, asid_a, model[(op == 6) ? 12 : 6].vppn), NO_REQ, NO_REQ);
            probe_all(asid_a);
        end

        // illegal sub-op leaves the table alone
        load_mixed_table(asid_a, asid_b);
        drive(inv_cmd(7 + int'(rand_bits(4)), asid_a, model[6].vppn), NO_REQ, NO_REQ);
        probe_all(asid_a);

        repeat (3) drive(NO_CMD, NO_REQ, NO_REQ);

        $display("errors: lookup %0d, read %0d, flag %0d", lookup_errors, read_errors,
                 flag_errors);
        if (lookup_errors + read_errors + flag_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("watchdog: stimulus did not finish within %0d time units", WATCHDOG_TIME);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: source/tlb_unit.sv
module tlb_unit #(
    parameter int TLBNUM = 16
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  tlbop_pkg::tlb_cmd_t       cmd,
    input  tlb_pkg::lookup_req_t      fetch_req,
    input  tlb_pkg::fetch_tag_t       fetch_tag,
    input  tlb_pkg::lookup_req_t      lsu_req,
    input  tlb_pkg::lsu_tag_t         lsu_tag,
    output tlb_pkg::lookup_rsp_t      fetch_rsp,
    output logic [$clog2(TLBNUM)-1:0] fetch_index,
    output tlb_pkg::fetch_tag_t       fetch_rsp_tag,
    output tlb_pkg::lookup_rsp_t      lsu_rsp,
    output logic [$clog2(TLBNUM)-1:0] lsu_index,
    output tlb_pkg::lsu_tag_t         lsu_rsp_tag,
    output logic                      rd_valid,
    output tlb_pkg::entry_t           rd_entry,
    output logic                      op_error
);

    localparam int IW = $clog2(TLBNUM);

    logic                         wr_en;
    logic [IW-1:0]                wr_index;
    tlb_pkg::entry_t              wr_entry;
    logic                         rd_en;
    logic [IW-1:0]                rd_index;
    logic                         inv_en;
    tlbop_pkg::inv_op_e           inv_op;
    logic [9:0]                   inv_asid;
    logic [18:0]                  inv_vppn;
    tlb_pkg::entry_t [TLBNUM-1:0] entries;

    tlb_cmd_decode #(
        .TLBNUM (TLBNUM)
    ) cmd_decode (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd      (cmd),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .inv_en   (inv_en),
        .inv_op   (inv_op),
        .inv_asid (inv_asid),
        .inv_vppn (inv_vppn),
        .op_error (op_error)
    );

    tlb_array #(
        .TLBNUM (TLBNUM)
    ) array (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .rd_index (rd_index),
        .inv_en   (inv_en),
        .inv_op   (inv_op),
        .inv_asid (inv_asid),
        .inv_vppn (inv_vppn),
        .entries  (entries),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry)
    );

    // both ports see the same table
    tlb_lookup #(
        .TLBNUM (TLBNUM),
        .tag_t  (tlb_pkg::fetch_tag_t)
    ) fetch_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .entries   (entries),
        .req       (fetch_req),
        .req_tag   (fetch_tag),
        .rsp       (fetch_rsp),
        .rsp_index (fetch_index),
        .rsp_tag   (fetch_rsp_tag)
    );

    tlb_lookup #(
        .TLBNUM (TLBNUM),
        .tag_t  (tlb_pkg::lsu_tag_t)
    ) lsu_lookup (
        .clk       (clk),
        .arst_n    (arst_n),
        .entries   (entries),
        .req       (lsu_req),
        .req_tag   (lsu_tag),
        .rsp       (lsu_rsp),
        .rsp_index (lsu_index),
        .rsp_tag   (lsu_rsp_tag)
    );

endmodule

// File: source/tlb_lookup.sv
module tlb_lookup #(
    parameter int  TLBNUM = 16,
    parameter type tag_t  = logic
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  tlb_pkg::entry_t [TLBNUM-1:0] entries,
    input  tlb_pkg::lookup_req_t         req,
    input  tag_t                         req_tag,
    output tlb_pkg::lookup_rsp_t         rsp,
    output logic [$clog2(TLBNUM)-1:0]    rsp_index,
    output tag_t                         rsp_tag
);

    localparam int IW = $clog2(TLBNUM);

    logic [TLBNUM-1:0] match;
    logic              hit;
    logic [IW-1:0]     hit_index;
    tlb_pkg::entry_t   hit_entry;
    logic              hit_4m;
    logic              odd_page;

    logic              valid_q;
    logic              found_q;
    logic [5:0]        ps_q;
    tlb_pkg::page_t    page_q;

    for (genvar i = 0; i < TLBNUM; i++) begin : g_match
        logic is_4m;

        assign is_4m    = (entries[i].ps == tlb_pkg::PS_4M);
        assign match[i] = entries[i].e
                       && (entries[i].vppn[18:10] == req.vppn[18:10])
                       && (is_4m || entries[i].vppn[9:0] == req.vppn[9:0])
                       && (entries[i].g || entries[i].asid == req.asid);
    end

    assign hit = |match;

    // at most one match, so OR-ing the indices is enough
    always_comb begin
        hit_index = '0;
        for (int i = 0; i < TLBNUM; i++) begin
            if (match[i]) begin
                hit_index = hit_index | IW'(i);
            end
        end
    end

    assign hit_entry = entries[hit_index];
    assign hit_4m    = (hit_entry.ps == tlb_pkg::PS_4M);
    // 4MB pair splits on vppn bit 8, 4KB pair on va bit 12
    assign odd_page  = hit_4m ? req.vppn[8] : req.va_bit12;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            found_q <= 1'b0;
        end else begin
            valid_q <= req.valid;
            found_q <= req.valid && hit;
        end
    end

    // miss returns zeros
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_tag <= req_tag;
            if (hit) begin
                ps_q      <= hit_4m ? tlb_pkg::PS_4M : tlb_pkg::PS_4K;
                page_q    <= odd_page ? hit_entry.page1 : hit_entry.page0;
                rsp_index <= hit_index;
            end else begin
                ps_q      <= '0;
                page_q    <= '0;
                rsp_index <= '0;
            end
        end
    end

    assign rsp.valid = valid_q;
    assign rsp.found = found_q;
    assign rsp.ps    = ps_q;
    assign rsp.page  = page_q;

    // overlapping entries would OR two indices together
    a_single_hit: assert property (
        @(posedge clk) disable iff (!arst_n)
        rsp.valid |-> $past($onehot0(match))
    ) else $error("lookup: request matched more than one entry");

endmodule

// File: source/tlb_array.sv
module tlb_array #(
    parameter int TLBNUM = 16
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         wr_en,
    input  logic [$clog2(TLBNUM)-1:0]    wr_index,
    input  tlb_pkg::entry_t              wr_entry,
    input  logic                         rd_en,
    input  logic [$clog2(TLBNUM)-1:0]    rd_index,
    input  logic                         inv_en,
    input  tlbop_pkg::inv_op_e           inv_op,
    input  logic [9:0]                   inv_asid,
    input  logic [18:0]                  inv_vppn,
    output tlb_pkg::entry_t [TLBNUM-1:0] entries,
    output logic                         rd_valid,
    output tlb_pkg::entry_t              rd_entry
);

    logic [TLBNUM-1:0] e_q;
    logic [TLBNUM-1:0] ps4m_q;
    logic [18:0]       vppn_q  [TLBNUM];
    logic [9:0]        asid_q  [TLBNUM];
    logic [TLBNUM-1:0] g_q;
    tlb_pkg::page_t    page0_q [TLBNUM];
    tlb_pkg::page_t    page1_q [TLBNUM];

    logic [TLBNUM-1:0] cond_asid;
    logic [TLBNUM-1:0] cond_va;
    logic [TLBNUM-1:0] inv_mask;

    for (genvar i = 0; i < TLBNUM; i++) begin : g_entry
        assign entries[i].e     = e_q[i];
        assign entries[i].vppn  = vppn_q[i];
        assign entries[i].ps    = ps4m_q[i] ? tlb_pkg::PS_4M : tlb_pkg::PS_4K;
        assign entries[i].asid  = asid_q[i];
        assign entries[i].g     = g_q[i];
        assign entries[i].page0 = page0_q[i];
        assign entries[i].page1 = page1_q[i];

        assign cond_asid[i] = (asid_q[i] == inv_asid);
        // low vppn bits are don't-care for a 4MB page
        assign cond_va[i]   = (vppn_q[i][18:10] == inv_vppn[18:10])
                           && (ps4m_q[i] || vppn_q[i][9:0] == inv_vppn[9:0]);
    end

    always_comb begin
        case (inv_op)
            tlbop_pkg::INV_ALL0,
            tlbop_pkg::INV_ALL1:         inv_mask = '1;
            tlbop_pkg::INV_GLOBAL:       inv_mask = g_q;
            tlbop_pkg::INV_NONGLOBAL:    inv_mask = ~g_q;
            tlbop_pkg::INV_ASID:         inv_mask = ~g_q & cond_asid;
            tlbop_pkg::INV_ASID_VA:      inv_mask = ~g_q & cond_asid & cond_va;
            tlbop_pkg::INV_G_OR_ASID_VA: inv_mask = (g_q | cond_asid) & cond_va;
            default:                     inv_mask = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_q <= '0;
        end else if (wr_en) begin
            e_q[wr_index] <= wr_entry.e;
        end else if (inv_en) begin
            e_q <= e_q & ~inv_mask;
        end
    end

    // size kept as a single flag
    always_ff @(posedge clk) begin
        if (wr_en) begin
            vppn_q[wr_index]  <= wr_entry.vppn;
            ps4m_q[wr_index]  <= (wr_entry.ps == tlb_pkg::PS_4M);
            asid_q[wr_index]  <= wr_entry.asid;
            g_q[wr_index]     <= wr_entry.g;
            page0_q[wr_index] <= wr_entry.page0;
            page1_q[wr_index] <= wr_entry.page1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_entry <= entries[rd_index];
        end
    end

    a_no_wr_inv: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(wr_en && inv_en)
    ) else $error("array: write and invalidate in one cycle");

endmodule

// File: source/tlb_cmd_decode.sv
module tlb_cmd_decode #(
    parameter int TLBNUM = 16
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  tlbop_pkg::tlb_cmd_t       cmd,
    output logic                      wr_en,
    output logic [$clog2(TLBNUM)-1:0] wr_index,
    output tlb_pkg::entry_t           wr_entry,
    output logic                      rd_en,
    output logic [$clog2(TLBNUM)-1:0] rd_index,
    output logic                      inv_en,
    output tlbop_pkg::inv_op_e        inv_op,
    output logic [9:0]                inv_asid,
    output logic [18:0]               inv_vppn,
    output logic                      op_error
);

    localparam int IW = $clog2(TLBNUM);

    logic [IW-1:0] fill_ptr;
    logic          is_wr;
    logic          is_fill;
    logic          is_rd;
    logic          is_inv;
    logic          inv_legal;

    assign is_wr   = cmd.valid && (cmd.op == tlbop_pkg::OP_WR);
    assign is_fill = cmd.valid && (cmd.op == tlbop_pkg::OP_FILL);
    assign is_rd   = cmd.valid && (cmd.op == tlbop_pkg::OP_RD);
    assign is_inv  = cmd.valid && (cmd.op == tlbop_pkg::OP_INV);

    assign inv_legal = (cmd.inv_op <= tlbop_pkg::INV_G_OR_ASID_VA);

    // write side, fill takes its slot from the pointer
    assign wr_en    = is_wr || is_fill;
    assign wr_index = is_fill ? fill_ptr : cmd.index[IW-1:0];
    assign wr_entry = cmd.entry;

    assign rd_en    = is_rd;
    assign rd_index = cmd.index[IW-1:0];

    // a bad sub-op never reaches the array
    assign inv_en   = is_inv && inv_legal;
    assign inv_op   = cmd.inv_op;
    assign inv_asid = cmd.asid;
    assign inv_vppn = cmd.vppn;

    // TLBNUM is a power of two so the pointer wraps on its own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_ptr <= '0;
        end else if (is_fill) begin
            fill_ptr <= fill_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_error <= 1'b0;
        end else begin
            op_error <= is_inv && !inv_legal;
        end
    end

    a_ctrl_onehot: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({wr_en, rd_en, inv_en})
    ) else $error("decode: more than one of wr_en/rd_en/inv_en");

endmodule

// File: source/tlbop_pkg.sv
package tlbop_pkg;

    typedef enum logic [1:0] {
        OP_WR   = 2'd0,
        OP_FILL = 2'd1,
        OP_RD   = 2'd2,
        OP_INV  = 2'd3
    } tlb_op_e;

    // invtlb sub-ops, anything above 6 is illegal
    typedef enum logic [4:0] {
        INV_ALL0        = 5'd0,
        INV_ALL1        = 5'd1,
        INV_GLOBAL      = 5'd2,
        INV_NONGLOBAL   = 5'd3,
        INV_ASID        = 5'd4,
        INV_ASID_VA     = 5'd5,
        INV_G_OR_ASID_VA = 5'd6
    } inv_op_e;

    // index is sized for the largest table
    typedef struct packed {
        logic             valid;
        tlb_op_e          op;
        inv_op_e          inv_op;
        logic [3:0]       index;
        logic [9:0]       asid;
        logic [18:0]      vppn;
        tlb_pkg::entry_t  entry;
    } tlb_cmd_t;

endpackage

// File: source/tlb_pkg.sv
package tlb_pkg;

    // page size codes as seen by software
    localparam logic [5:0] PS_4K = 6'd12;
    localparam logic [5:0] PS_4M = 6'd21;

    // one half of an even/odd page pair
    typedef struct packed {
        logic [19:0] ppn;
        logic [1:0]  plv;
        logic [1:0]  mat;
        logic        d;
        logic        v;
    } page_t;

    typedef struct packed {
        logic        e;
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic [9:0]  asid;
        logic        g;
        page_t       page0;
        page_t       page1;
    } entry_t;

    // va_bit12 picks the odd page of a 4KB pair
    typedef struct packed {
        logic        valid;
        logic [18:0] vppn;
        logic        va_bit12;
        logic [9:0]  asid;
    } lookup_req_t;

    // index travels beside the response, its width follows TLBNUM
    typedef struct packed {
        logic        valid;
        logic        found;
        logic [5:0]  ps;
        page_t       page;
    } lookup_rsp_t;

    // fetch sequence number
    typedef logic [7:0] fetch_tag_t;

    typedef struct packed {
        logic       store;
        logic [4:0] slot;
    } lsu_tag_t;

endpackage
